//--- files.f
irc_pkg.sv
irc_factor.sv
irc_arbiter.sv
irc_bus_decoder.sv
irc_top.sv
tb_irc_top.sv

//--- irc_arbiter.sv
// interrupt arbiter
// global enable and mask registers, the wired-AND sense line and the
// round sequencer that collects the winning packet and drives irq

`timescale 1ns/10ps

module irc_arbiter import irc_pkg::*; #(
	parameter int FACTOR_NUM      = 4,
	parameter int FACTOR_ID_WIDTH = 2,
	parameter int PRIORITY_WIDTH  = 3
) (
	input  logic                  clk,
	input  logic                  reset,

	// register access
	input  irc_slot_req_t         slot_req_i,
	output irc_data_t             slot_dat_o,

	// serial arbitration
	input  logic [FACTOR_NUM-1:0] request_send_i,
	output logic                  request_sense_o,
	output logic                  request_start_o,
	output logic                  request_reset_o,

	output logic                  irq_o
);

	localparam int PACKET_WIDTH = PRIORITY_WIDTH + FACTOR_ID_WIDTH;
	localparam int CNT_WIDTH    = $clog2(PACKET_WIDTH);

	irc_arb_state_t             state;
	logic [CNT_WIDTH-1:0]       bit_cnt;
	logic [PACKET_WIDTH-1:0]    collect;
	logic [PACKET_WIDTH-1:0]    sensed_packet;
	logic [PRIORITY_WIDTH-1:0]  sensed_priority;
	logic                       last_bit;
	logic                       packet_win;
	logic                       global_enable;
	logic [PRIORITY_WIDTH-1:0]  global_mask;
	logic [FACTOR_ID_WIDTH-1:0] winner_id;
	logic [PRIORITY_WIDTH-1:0]  winner_priority;
	logic                       slot_write;
	logic                       ack_write;
	logic                       enable_clear;

	assign slot_write = slot_req_i.stb & slot_req_i.we;
	assign ack_write  = slot_write && slot_req_i.adr == IRC_GLOBAL_FACTOR;
	// disable acts at the same edge as the write
	assign enable_clear = slot_write && slot_req_i.adr == IRC_GLOBAL_ENABLE &&
		!slot_req_i.dat[0];

	// line is low as soon as any factor sends a zero
	assign request_sense_o = &request_send_i;
	assign request_start_o = state == ST_START;

	// ------------------------------------------------------------------------
	// packet collection
	// ------------------------------------------------------------------------
	assign sensed_packet   = {collect[PACKET_WIDTH-2:0], request_sense_o};
	assign sensed_priority = sensed_packet[PACKET_WIDTH-1:FACTOR_ID_WIDTH];
	assign last_bit        = bit_cnt == CNT_WIDTH'(PACKET_WIDTH - 1);

	// all ones means nobody competed
	assign packet_win = (sensed_packet != {PACKET_WIDTH{1'b1}}) &&
		(sensed_priority < global_mask);

	always_ff @(posedge clk) begin
		if (state == ST_SHIFT) begin
			collect <= sensed_packet;
		end
		if (state == ST_SHIFT && last_bit && packet_win && global_enable) begin
			winner_id       <= sensed_packet[FACTOR_ID_WIDTH-1:0];
			winner_priority <= sensed_priority;
		end
	end

	// ------------------------------------------------------------------------
	// sequencer
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			state           <= ST_IDLE;
			bit_cnt         <= '0;
			irq_o           <= 1'b0;
			request_reset_o <= 1'b0;
		end else begin
			request_reset_o <= 1'b0;
			if (!global_enable || enable_clear) begin
				// abort whatever round is in flight
				if (state != ST_IDLE) begin
					request_reset_o <= 1'b1;
				end
				state <= ST_IDLE;
				irq_o <= 1'b0;
			end else begin
				case (state)
					ST_IDLE: begin
						state <= ST_START;
					end
					ST_START: begin
						bit_cnt <= '0;
						state   <= ST_SHIFT;
					end
					ST_SHIFT: begin
						bit_cnt <= bit_cnt + 1'b1;
						if (last_bit) begin
							if (packet_win) begin
								irq_o <= 1'b1;
								state <= ST_WAIT_ACK;
							end else begin
								request_reset_o <= 1'b1;
								state           <= ST_IDLE;
							end
						end
					end
					ST_WAIT_ACK: begin
						if (ack_write) begin
							irq_o           <= 1'b0;
							request_reset_o <= 1'b1;
							state           <= ST_IDLE;
						end
					end
					default: begin
						state <= ST_IDLE;
					end
				endcase
			end
		end
	end

	// ------------------------------------------------------------------------
	// global registers
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			global_enable <= 1'b0;
			global_mask   <= {PRIORITY_WIDTH{1'b1}};
		end else begin
			if (slot_write && slot_req_i.adr == IRC_GLOBAL_ENABLE) begin
				global_enable <= slot_req_i.dat[0];
			end
			if (slot_write && slot_req_i.adr == IRC_GLOBAL_MASK) begin
				global_mask <= slot_req_i.dat[PRIORITY_WIDTH-1:0];
			end
		end
	end

	always_comb begin
		slot_dat_o = '0;
		if (slot_req_i.stb) begin
			case (slot_req_i.adr)
				IRC_GLOBAL_ENABLE:   slot_dat_o = irc_data_t'(global_enable);
				IRC_GLOBAL_MASK:     slot_dat_o = irc_data_t'(global_mask);
				IRC_GLOBAL_FACTOR:   slot_dat_o = irc_data_t'(winner_id);
				IRC_GLOBAL_PRIORITY: slot_dat_o = irc_data_t'(winner_priority);
				default:             slot_dat_o = '0;
			endcase
		end
	end

endmodule

//--- irc_bus_decoder.sv
// interrupt controller bus decoder
// splits the wishbone word address into slot number and register
// offset, routes the strobe to one slot and selects its read word

`timescale 1ns/10ps

module irc_bus_decoder import irc_pkg::*; #(
	parameter  int FACTOR_NUM     = 4,
	localparam int SLOT_ADR_WIDTH = $clog2(FACTOR_NUM + 1)
) (
	// wishbone slave
	input  logic [SLOT_ADR_WIDTH+1:0] wb_adr_i,
	input  irc_data_t                 wb_dat_i,
	input  logic                      wb_we_i,
	input  logic                      wb_stb_i,
	output irc_data_t                 wb_dat_o,
	output logic                      wb_ack_o,

	// slot 0 arbiter, slot k+1 factor k
	output irc_slot_req_t             slot_req_o [0:FACTOR_NUM],
	input  irc_data_t                 slot_dat_i [0:FACTOR_NUM]
);

	logic [SLOT_ADR_WIDTH-1:0] slot_num;
	irc_reg_adr_t              reg_adr;

	assign slot_num = wb_adr_i[SLOT_ADR_WIDTH+1:2];
	assign reg_adr  = wb_adr_i[1:0];

	// no wait states
	assign wb_ack_o = wb_stb_i;

	// ------------------------------------------------------------------------
	// request fan-out
	// ------------------------------------------------------------------------
	always_comb begin
		for (int i = 0; i <= FACTOR_NUM; i++) begin
			slot_req_o[i].adr = reg_adr;
			slot_req_o[i].dat = wb_dat_i;
			slot_req_o[i].we  = wb_we_i;
			// strobe only in the addressed slot
			slot_req_o[i].stb = wb_stb_i && (slot_num == SLOT_ADR_WIDTH'(i));
		end
	end

	// ------------------------------------------------------------------------
	// read mux
	// ------------------------------------------------------------------------
	always_comb begin
		wb_dat_o = '0;
		if (wb_stb_i) begin
			// unused slot numbers fall through as zero
			for (int i = 0; i <= FACTOR_NUM; i++) begin
				if (slot_num == SLOT_ADR_WIDTH'(i)) begin
					wb_dat_o = slot_dat_i[i];
				end
			end
		end
	end

endmodule

//--- irc_factor.sv
// interrupt factor
// latches one interrupt source, holds its enable, pending and
// priority registers and sends its packet on the serial arbitration line

`timescale 1ns/10ps

module irc_factor import irc_pkg::*; #(
	parameter int FACTOR_ID_WIDTH = 2,
	parameter int PRIORITY_WIDTH  = 3
) (
	input  logic                       clk,
	input  logic                       reset,

	input  logic [FACTOR_ID_WIDTH-1:0] factor_id_i,
	input  logic                       interrupt_i,

	// serial arbitration
	input  logic                       request_reset_i,
	input  logic                       request_start_i,
	input  logic                       request_sense_i,
	output logic                       request_send_o,

	// register access
	input  irc_slot_req_t              slot_req_i,
	output irc_data_t                  slot_dat_o
);

	localparam int PACKET_WIDTH = PRIORITY_WIDTH + FACTOR_ID_WIDTH;

	logic                      reg_enable;
	logic                      reg_pending;
	logic [PRIORITY_WIDTH-1:0] reg_priority;
	logic [PACKET_WIDTH-1:0]   send_packet;
	logic                      slot_write;
	logic                      competing;
	logic                      lost_bit;

	assign slot_write = slot_req_i.stb & slot_req_i.we;
	assign competing  = reg_enable & reg_pending;

	// ------------------------------------------------------------------------
	// packet sender
	// ------------------------------------------------------------------------
	assign request_send_o = send_packet[PACKET_WIDTH-1];
	// line went low while we sent high
	assign lost_bit = request_send_o != request_sense_i;

	always_ff @(posedge clk) begin
		if (reset) begin
			send_packet <= {PACKET_WIDTH{1'b1}};
		end else if (request_reset_i || lost_bit) begin
			send_packet <= {PACKET_WIDTH{1'b1}};
		end else if (request_start_i && competing) begin
			send_packet <= {reg_priority, factor_id_i};
		end else begin
			// msb first, ones shifted in behind
			send_packet <= {send_packet[PACKET_WIDTH-2:0], 1'b1};
		end
	end

	// ------------------------------------------------------------------------
	// registers
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			reg_enable   <= 1'b0;
			reg_pending  <= 1'b0;
			reg_priority <= '0;
		end else begin
			if (slot_write && slot_req_i.adr == IRC_FACTOR_ENABLE) begin
				reg_enable <= slot_req_i.dat[0];
			end

			// source wins over a bus clear
			if (interrupt_i) begin
				reg_pending <= 1'b1;
			end else if (slot_write && slot_req_i.adr == IRC_FACTOR_PENDING) begin
				reg_pending <= slot_req_i.dat[0];
			end

			if (slot_write && slot_req_i.adr == IRC_FACTOR_PRIORITY) begin
				reg_priority <= slot_req_i.dat[PRIORITY_WIDTH-1:0];
			end
		end
	end

	// read data, zero outside a strobe
	always_comb begin
		slot_dat_o = '0;
		if (slot_req_i.stb) begin
			case (slot_req_i.adr)
				IRC_FACTOR_ENABLE:   slot_dat_o = irc_data_t'(reg_enable);
				IRC_FACTOR_PENDING:  slot_dat_o = irc_data_t'(reg_pending);
				IRC_FACTOR_STATUS:   slot_dat_o = irc_data_t'(interrupt_i);
				IRC_FACTOR_PRIORITY: slot_dat_o = irc_data_t'(reg_priority);
				default:             slot_dat_o = '0;
			endcase
		end
	end

endmodule

//--- irc_pkg.sv
// interrupt controller shared definitions
// bus word and slot request types, the register map of the
// global and factor slots, and the arbiter sequencer states

package irc_pkg;

	// bus word and register offset inside a slot
	typedef logic [31:0] irc_data_t;
	typedef logic [1:0]  irc_reg_adr_t;

	// request routed by the decoder to one slot
	typedef struct packed {
		irc_reg_adr_t adr;
		irc_data_t    dat;
		logic         we;
		logic         stb;
	} irc_slot_req_t;

	// ------------------------------------------------------------------------
	// factor slot registers
	// ------------------------------------------------------------------------
	localparam irc_reg_adr_t IRC_FACTOR_ENABLE   = 2'd0;
	localparam irc_reg_adr_t IRC_FACTOR_PENDING  = 2'd1;
	localparam irc_reg_adr_t IRC_FACTOR_STATUS   = 2'd2;
	localparam irc_reg_adr_t IRC_FACTOR_PRIORITY = 2'd3;

	// ------------------------------------------------------------------------
	// global slot registers
	// ------------------------------------------------------------------------
	localparam irc_reg_adr_t IRC_GLOBAL_ENABLE   = 2'd0;
	localparam irc_reg_adr_t IRC_GLOBAL_MASK     = 2'd1;
	// read gives winning id, write acknowledges
	localparam irc_reg_adr_t IRC_GLOBAL_FACTOR   = 2'd2;
	localparam irc_reg_adr_t IRC_GLOBAL_PRIORITY = 2'd3;

	// arbitration sequencer
	typedef enum logic [1:0] {ST_IDLE, ST_START, ST_SHIFT, ST_WAIT_ACK} irc_arb_state_t;

endpackage

//--- irc_top.sv
// interrupt controller top level
// wishbone decoder, central arbiter and one factor block per
// interrupt source, joined over the serial arbitration line

`timescale 1ns/10ps

module irc_top import irc_pkg::*; #(
	parameter  int FACTOR_NUM      = 4,
	parameter  int FACTOR_ID_WIDTH = 2,
	parameter  int PRIORITY_WIDTH  = 3,
	localparam int SLOT_ADR_WIDTH  = $clog2(FACTOR_NUM + 1)
) (
	input  logic                      clk,
	input  logic                      reset,

	// wishbone slave
	input  logic [SLOT_ADR_WIDTH+1:0] wb_adr_i,
	input  irc_data_t                 wb_dat_i,
	input  logic                      wb_we_i,
	input  logic                      wb_stb_i,
	output irc_data_t                 wb_dat_o,
	output logic                      wb_ack_o,

	input  logic [FACTOR_NUM-1:0]     interrupt_i,
	output logic                      irq_o
);

	irc_slot_req_t         slot_req [0:FACTOR_NUM];
	irc_data_t             slot_dat [0:FACTOR_NUM];

	// arbitration line
	logic [FACTOR_NUM-1:0] request_send;
	logic                  request_sense;
	logic                  request_start;
	logic                  request_reset;

	irc_bus_decoder #(
		.FACTOR_NUM (FACTOR_NUM)
	) irc_bus_decoder_i (
		.wb_adr_i   (wb_adr_i),
		.wb_dat_i   (wb_dat_i),
		.wb_we_i    (wb_we_i),
		.wb_stb_i   (wb_stb_i),
		.wb_dat_o   (wb_dat_o),
		.wb_ack_o   (wb_ack_o),
		.slot_req_o (slot_req),
		.slot_dat_i (slot_dat)
	);

	irc_arbiter #(
		.FACTOR_NUM      (FACTOR_NUM),
		.FACTOR_ID_WIDTH (FACTOR_ID_WIDTH),
		.PRIORITY_WIDTH  (PRIORITY_WIDTH)
	) irc_arbiter_i (
		.clk             (clk),
		.reset           (reset),
		.slot_req_i      (slot_req[0]),
		.slot_dat_o      (slot_dat[0]),
		.request_send_i  (request_send),
		.request_sense_o (request_sense),
		.request_start_o (request_start),
		.request_reset_o (request_reset),
		.irq_o           (irq_o)
	);

	// factor k sits in slot k+1
	for (genvar g = 0; g < FACTOR_NUM; g++) begin : gen_factor
		irc_factor #(
			.FACTOR_ID_WIDTH (FACTOR_ID_WIDTH),
			.PRIORITY_WIDTH  (PRIORITY_WIDTH)
		) irc_factor_i (
			.clk             (clk),
			.reset           (reset),
			.factor_id_i     (FACTOR_ID_WIDTH'(g)),
			.interrupt_i     (interrupt_i[g]),
			.request_reset_i (request_reset),
			.request_start_i (request_start),
			.request_sense_i (request_sense),
			.request_send_o  (request_send[g]),
			.slot_req_i      (slot_req[g+1]),
			.slot_dat_o      (slot_dat[g+1])
		);
	end

endmodule

//--- tb_irc_top.sv
// interrupt controller testbench
// random register, arbitration, mask, service and disable checks
// against a model of the factor and global registers

`timescale 1ns/10ps

module tb_irc_top import irc_pkg::*; ();

	localparam int FACTOR_NUM      = 4;
	localparam int FACTOR_ID_WIDTH = 2;
	localparam int PRIORITY_WIDTH  = 3;
	localparam int SLOT_ADR_WIDTH  = $clog2(FACTOR_NUM + 1);
	localparam int ROUND_LEN       = PRIORITY_WIDTH + FACTOR_ID_WIDTH + 2;
	localparam int PRIORITY_MAX    = (1 << PRIORITY_WIDTH) - 1;
	localparam int ID_MASK         = (1 << FACTOR_ID_WIDTH) - 1;

	logic                      clk;
	logic                      reset;
	logic [SLOT_ADR_WIDTH+1:0] wb_adr;
	irc_data_t                 wb_dat_w;
	logic                      wb_we;
	logic                      wb_stb;
	irc_data_t                 wb_dat_r;
	logic                      wb_ack;
	logic [FACTOR_NUM-1:0]     interrupt;
	logic                      irq;

	// model of the registers
	bit m_enable  [FACTOR_NUM];
	bit m_pending [FACTOR_NUM];
	int m_priority[FACTOR_NUM];
	bit m_global_enable;
	int m_mask;

	integer seed;
	int     check_errors;
	int     timeout_errors;

	irc_top irc_top_i (
		.clk         (clk),
		.reset       (reset),
		.wb_adr_i    (wb_adr),
		.wb_dat_i    (wb_dat_w),
		.wb_we_i     (wb_we),
		.wb_stb_i    (wb_stb),
		.wb_dat_o    (wb_dat_r),
		.wb_ack_o    (wb_ack),
		.interrupt_i (interrupt),
		.irq_o       (irq)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ------------------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------------------
	function automatic int rand_below(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	function automatic logic [SLOT_ADR_WIDTH+1:0] reg_addr(input int slot,
		input irc_reg_adr_t adr);
		return {SLOT_ADR_WIDTH'(slot), adr};
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t: %s expected %0h, actual %0h",
				$time, name, expected, actual);
			check_errors++;
		end
	endtask

	task automatic bus_write(input logic [SLOT_ADR_WIDTH+1:0] adr, input irc_data_t data);
		@(negedge clk);
		wb_adr   = adr;
		wb_dat_w = data;
		wb_we    = 1'b1;
		wb_stb   = 1'b1;
		#2;
		check_value("wb_ack_o", 1, wb_ack);
		@(negedge clk);
		wb_we  = 1'b0;
		wb_stb = 1'b0;
	endtask

	task automatic bus_read(input logic [SLOT_ADR_WIDTH+1:0] adr, output irc_data_t data);
		@(negedge clk);
		wb_adr = adr;
		wb_we  = 1'b0;
		wb_stb = 1'b1;
		// read word is combinational
		#2;
		check_value("wb_ack_o", 1, wb_ack);
		data = wb_dat_r;
		@(negedge clk);
		wb_stb = 1'b0;
	endtask

	task automatic check_read(input logic [SLOT_ADR_WIDTH+1:0] adr, input string name,
		input logic [31:0] expected);
		irc_data_t data;
		bus_read(adr, data);
		check_value(name, expected, data);
	endtask

	task automatic write_factor(input int k, input irc_reg_adr_t adr, input irc_data_t data);
		bus_write(reg_addr(k + 1, adr), data);
		case (adr)
			IRC_FACTOR_ENABLE:   m_enable[k] = data[0];
			IRC_FACTOR_PENDING:  m_pending[k] = data[0];
			IRC_FACTOR_PRIORITY: m_priority[k] = data[PRIORITY_WIDTH-1:0];
			default: ;
		endcase
	endtask

	task automatic write_global(input irc_reg_adr_t adr, input irc_data_t data);
		bus_write(reg_addr(0, adr), data);
		if (adr == IRC_GLOBAL_ENABLE) begin
			m_global_enable = data[0];
		end else if (adr == IRC_GLOBAL_MASK) begin
			m_mask = data[PRIORITY_WIDTH-1:0];
		end
	endtask

	task automatic pulse_interrupts(input logic [FACTOR_NUM-1:0] bits);
		@(negedge clk);
		interrupt = bits;
		@(negedge clk);
		interrupt = '0;
		for (int k = 0; k < FACTOR_NUM; k++) begin
			if (bits[k]) begin
				m_pending[k] = 1'b1;
			end
		end
	endtask

	// lowest {priority, id} among enabled and pending, -1 if none, masked or disabled
	function automatic int predict_packet();
		int best;
		int packet;
		best = -1;
		for (int k = 0; k < FACTOR_NUM; k++) begin
			packet = (m_priority[k] << FACTOR_ID_WIDTH) | k;
			if (m_enable[k] && m_pending[k] && (best < 0 || packet < best)) begin
				best = packet;
			end
		end
		if (!m_global_enable || (best >= 0 && (best >> FACTOR_ID_WIDTH) >= m_mask)) begin
			best = -1;
		end
		return best;
	endfunction

	task automatic wait_for_irq(input int limit);
		int cycles;
		cycles = 0;
		while (irq !== 1'b1 && cycles < limit) begin
			@(negedge clk);
			cycles++;
		end
		if (irq !== 1'b1) begin
			$display("timeout at %0t: irq_o did not rise within %0d cycles", $time, limit);
			timeout_errors++;
		end
	endtask

	task automatic expect_irq_low(input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			check_value("irq_o", 0, irq);
		end
	endtask

	task automatic check_winner();
		int packet;
		packet = predict_packet();
		check_read(reg_addr(0, IRC_GLOBAL_FACTOR), "winner id", packet & ID_MASK);
		check_read(reg_addr(0, IRC_GLOBAL_PRIORITY), "winner priority",
			packet >> FACTOR_ID_WIDTH);
	endtask

	// take each predicted winner in turn until nothing is left
	task automatic service_all();
		int packet;
		int round;
		packet = predict_packet();
		for (round = 0; round <= FACTOR_NUM && packet >= 0; round++) begin
			wait_for_irq(2 * ROUND_LEN);
			check_winner();
			write_factor(packet & ID_MASK, IRC_FACTOR_PENDING, 0);
			write_global(IRC_GLOBAL_FACTOR, 0);
			check_value("irq_o after ack", 0, irq);
			packet = predict_packet();
		end
		expect_irq_low(3 * ROUND_LEN);
	endtask

	// ------------------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------------------
	initial begin
		int                    f;
		int                    p;
		int                    m;
		logic [FACTOR_NUM-1:0] bits;

		seed            = 87248;
		check_errors    = 0;
		timeout_errors  = 0;
		reset           = 1'b1;
		wb_adr          = '0;
		wb_dat_w        = '0;
		wb_we           = 1'b0;
		wb_stb          = 1'b0;
		interrupt       = '0;
		m_global_enable = 1'b0;
		m_mask          = PRIORITY_MAX;
		for (int k = 0; k < FACTOR_NUM; k++) begin
			m_enable[k]   = 1'b0;
			m_pending[k]  = 1'b0;
			m_priority[k] = 0;
		end
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// register access
		for (int k = 0; k < FACTOR_NUM; k++) begin
			write_factor(k, IRC_FACTOR_ENABLE, rand_below(2));
			write_factor(k, IRC_FACTOR_PRIORITY, rand_below(PRIORITY_MAX + 1));
		end
		write_global(IRC_GLOBAL_MASK, rand_below(PRIORITY_MAX + 1));
		for (int k = 0; k < FACTOR_NUM; k++) begin
			check_read(reg_addr(k + 1, IRC_FACTOR_ENABLE), "factor enable", m_enable[k]);
			check_read(reg_addr(k + 1, IRC_FACTOR_PRIORITY), "factor priority",
				m_priority[k]);
		end
		check_read(reg_addr(0, IRC_GLOBAL_MASK), "global mask", m_mask);
		check_read(reg_addr(FACTOR_NUM + 1, 0), "unused slot", 0);
		bits = rand_below(1 << FACTOR_NUM);
		@(negedge clk);
		interrupt = bits;
		for (int k = 0; k < FACTOR_NUM; k++) begin
			check_read(reg_addr(k + 1, IRC_FACTOR_STATUS), "factor status", bits[k]);
		end
		@(negedge clk);
		interrupt = '0;
		// held status input also set pending
		for (int k = 0; k < FACTOR_NUM; k++) begin
			write_factor(k, IRC_FACTOR_PENDING, 0);
		end
		pulse_interrupts('1);
		for (int k = 0; k < FACTOR_NUM; k++) begin
			check_read(reg_addr(k + 1, IRC_FACTOR_PENDING), "factor pending", 1);
			write_factor(k, IRC_FACTOR_PENDING, 0);
			check_read(reg_addr(k + 1, IRC_FACTOR_PENDING), "factor pending", 0);
		end

		// single source
		write_global(IRC_GLOBAL_MASK, PRIORITY_MAX);
		f = rand_below(FACTOR_NUM);
		for (int k = 0; k < FACTOR_NUM; k++) begin
			write_factor(k, IRC_FACTOR_ENABLE, k == f);
		end
		write_factor(f, IRC_FACTOR_PRIORITY, rand_below(PRIORITY_MAX));
		pulse_interrupts(1 << f);
		write_global(IRC_GLOBAL_ENABLE, 1);
		service_all();

		// competition with ties, then the service sequence
		for (int trial = 0; trial < 6; trial++) begin
			write_global(IRC_GLOBAL_ENABLE, 0);
			for (int k = 0; k < FACTOR_NUM; k++) begin
				write_factor(k, IRC_FACTOR_ENABLE, 1);
				write_factor(k, IRC_FACTOR_PRIORITY, rand_below(3));
			end
			pulse_interrupts(rand_below((1 << FACTOR_NUM) - 1) + 1);
			write_global(IRC_GLOBAL_ENABLE, 1);
			service_all();
		end

		// mask
		write_global(IRC_GLOBAL_ENABLE, 0);
		f = rand_below(FACTOR_NUM);
		m = 1 + rand_below(PRIORITY_MAX - 1);
		p = m + rand_below(PRIORITY_MAX + 1 - m);
		for (int k = 0; k < FACTOR_NUM; k++) begin
			write_factor(k, IRC_FACTOR_ENABLE, k == f);
		end
		write_global(IRC_GLOBAL_MASK, m);
		write_factor(f, IRC_FACTOR_PRIORITY, p);
		pulse_interrupts(1 << f);
		write_global(IRC_GLOBAL_ENABLE, 1);
		expect_irq_low(3 * ROUND_LEN);
		write_factor(f, IRC_FACTOR_PRIORITY, rand_below(m));
		service_all();

		// global disable while irq is up
		write_global(IRC_GLOBAL_MASK, PRIORITY_MAX);
		write_factor(f, IRC_FACTOR_PRIORITY, rand_below(PRIORITY_MAX));
		pulse_interrupts(1 << f);
		wait_for_irq(2 * ROUND_LEN);
		write_global(IRC_GLOBAL_ENABLE, 0);
		check_value("irq_o after disable", 0, irq);
		expect_irq_low(3 * ROUND_LEN);
		write_global(IRC_GLOBAL_ENABLE, 1);
		service_all();

		$display("errors: %0d check, %0d timeout", check_errors, timeout_errors);
		if (check_errors == 0 && timeout_errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule
